// File: include/etx_settings.svh
`ifndef ETX_SETTINGS_SVH
`define ETX_SETTINGS_SVH

// ##################################################
// fifo sizing
// ##################################################

// entries per channel fifo
// also the deepest burst preloaded per channel
`define ETX_FIFO_DEPTH 8

// ##################################################
// link frame lengths, in bytes
// ##################################################

// writes and read responses carry the full word
`define ETX_FULL_BYTES 13
// read requests drop the 4 data bytes
`define ETX_RQ_BYTES 9

// cycle limit for any testbench wait loop
`define ETX_TIMEOUT 400

`endif

// File: rtl/etx_link_pkg.sv
package etx_link_pkg;

  // ##################################################
  // link side types
  // ##################################################

  // one byte on the parallel link
  typedef logic [7:0] link_byte_t;

  // byte index inside a frame
  // 4 bits covers the 13 byte frame
  typedef logic [3:0] frame_cnt_t;

endpackage

// File: rtl/emesh_pkg.sv
`include "etx_settings.svh"

package emesh_pkg;
  import etx_link_pkg::*;

  // source channels, highest priority first
  typedef enum logic [1:0] {
    CHAN_RR = 2'd0,
    CHAN_RQ = 2'd1,
    CHAN_WR = 2'd2
  } etx_chan_t;

  // emesh transaction, 103 bits plus a leading pad bit
  typedef struct packed {
    logic        pad;
    logic        write;
    logic [1:0]  datamode;
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic [31:0] srcaddr;
    logic [31:0] data;
  } emesh_packet_t;

  // same 104 bits seen as fields or as link byte lanes
  // lane 12 is the first byte on the wire
  typedef union packed {
    emesh_packet_t                      pkt;
    link_byte_t [`ETX_FULL_BYTES-1:0]   lanes;
  } emesh_word_t;

endpackage

// File: rtl/emesh_if.sv
`timescale 1ns/1ps

interface emesh_if import emesh_pkg::*; ();

  // transaction offered while access is high
  logic        access;
  // held stable until ack
  emesh_word_t packet;
  // one cycle pulse with the last link byte
  logic        ack;

  // arbiter side
  modport master (
    output access,
    output packet,
    input  ack
  );

  // framer side
  modport slave (
    input  access,
    input  packet,
    output ack
  );

endinterface

// File: rtl/etx_fifo.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_fifo import emesh_pkg::*; (
  input  logic        tx_lclk_par,
  input  logic        reset,
  input  logic        push,
  input  emesh_word_t push_data,
  input  logic        rd_en,
  output emesh_word_t rd_data,
  output logic        empty,
  output logic        full
);

  localparam int DEPTH = `ETX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  emesh_word_t   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  // push while full is dropped
  assign do_push = push & ~full;
  assign do_pop  = rd_en & ~empty;

  assign empty   = (count == '0);
  assign full    = (count == (AW + 1)'(DEPTH));
  // head word, valid whenever empty is low
  assign rd_data = mem[rd_ptr];

  // ##################################################
  // pointers and occupancy
  // ##################################################
  always_ff @(posedge tx_lclk_par) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge tx_lclk_par) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// File: rtl/etx_arbiter.sv
`timescale 1ns/1ps

module etx_arbiter import emesh_pkg::*; (
  input  logic        tx_lclk_par,
  input  logic        reset,
  // read response fifo
  input  emesh_word_t rr_data,
  input  logic        rr_empty,
  output logic        rr_rd_en,
  // read request fifo
  input  emesh_word_t rq_data,
  input  logic        rq_empty,
  output logic        rq_rd_en,
  // write fifo
  input  emesh_word_t wr_data,
  input  logic        wr_empty,
  output logic        wr_rd_en,
  // link back-pressure levels
  input  logic        rd_wait,
  input  logic        wr_wait,
  emesh_if.master     tx
);

  logic        rr_ready;
  logic        rq_ready;
  logic        wr_ready;
  logic        pick;
  etx_chan_t   pick_chan;
  emesh_word_t pick_data;
  logic        access_q;
  emesh_word_t packet_q;

  // ##################################################
  // fixed priority, rr over rq over wr
  // ##################################################

  // responses go out as writes, so wr_wait holds them
  assign rr_ready = ~rr_empty & ~wr_wait;
  assign rq_ready = ~rq_empty & ~rd_wait & ~rr_ready;
  assign wr_ready = ~wr_empty & ~wr_wait & ~rr_ready & ~rq_ready;

  // new pick only when idle or on the ack of the current one
  assign pick = (rr_ready | rq_ready | wr_ready) & (~access_q | tx.ack);

  always_comb begin
    pick_chan = CHAN_WR;
    if (rr_ready) begin
      pick_chan = CHAN_RR;
    end else if (rq_ready) begin
      pick_chan = CHAN_RQ;
    end
  end

  // one pop per pick, combinational in the pick cycle
  assign rr_rd_en = pick & (pick_chan == CHAN_RR);
  assign rq_rd_en = pick & (pick_chan == CHAN_RQ);
  assign wr_rd_en = pick & (pick_chan == CHAN_WR);

  // head word of the granted fifo
  always_comb begin
    case (pick_chan)
      CHAN_RR: pick_data = rr_data;
      CHAN_RQ: pick_data = rq_data;
      default: pick_data = wr_data;
    endcase
  end

  // ##################################################
  // hold granted transaction until ack
  // ##################################################
  always_ff @(posedge tx_lclk_par) begin
    if (reset) begin
      access_q <= 1'b0;
    end else if (pick) begin
      access_q <= 1'b1;
    end else if (tx.ack) begin
      access_q <= 1'b0;
    end
  end

  always_ff @(posedge tx_lclk_par) begin
    if (pick) begin
      packet_q <= pick_data;
    end
  end

  assign tx.access = access_q;
  assign tx.packet = packet_q;

endmodule

// File: rtl/etx_framer.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_framer import etx_link_pkg::*; (
  input  logic       tx_lclk_par,
  input  logic       reset,
  emesh_if.slave     rx,
  output logic       link_frame,
  output link_byte_t link_byte
);

  localparam frame_cnt_t LAST_FULL = frame_cnt_t'(`ETX_FULL_BYTES - 1);
  localparam frame_cnt_t LAST_RQ   = frame_cnt_t'(`ETX_RQ_BYTES - 1);

  logic       run;
  frame_cnt_t cnt;
  frame_cnt_t last_idx;
  frame_cnt_t lane_idx;
  logic       is_rq;
  logic       last;

  // ##################################################
  // frame length
  // ##################################################

  // responses carry the write bit, so write low means read request
  // datamode only sizes the read, any value is legal
  assign is_rq    = ~rx.packet.pkt.write;
  // request frame stops before the data lanes
  assign last_idx = is_rq ? LAST_RQ : LAST_FULL;

  // ##################################################
  // byte lanes out, msb first
  // ##################################################

  // drops for one cycle after an ack with no follow-on pick
  assign link_frame = run & rx.access;
  assign last       = link_frame & (cnt == last_idx);
  // ack rides on the last byte
  assign rx.ack     = last;

  // byte 0 is lane 12
  assign lane_idx  = LAST_FULL - cnt;
  assign link_byte = link_frame ? rx.packet.lanes[lane_idx] : '0;

  // run rises the cycle after access, stays up across back to back frames
  always_ff @(posedge tx_lclk_par) begin
    if (reset) begin
      run <= 1'b0;
      cnt <= '0;
    end else if (!run) begin
      run <= rx.access;
      cnt <= '0;
    end else if (!rx.access) begin
      // arbiter went idle after the last ack
      run <= 1'b0;
      cnt <= '0;
    end else if (last) begin
      // next packet loads on this edge
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: rtl/etx_top.sv
`timescale 1ns/1ps

module etx_top import emesh_pkg::*, etx_link_pkg::*; (
  input  logic          tx_lclk_par,
  input  logic          reset,
  // read responses
  input  emesh_packet_t rr_packet,
  input  logic          rr_push,
  output logic          rr_full,
  // read requests
  input  emesh_packet_t rq_packet,
  input  logic          rq_push,
  output logic          rq_full,
  // writes
  input  emesh_packet_t wr_packet,
  input  logic          wr_push,
  output logic          wr_full,
  // link side
  input  logic          link_rd_wait,
  input  logic          link_wr_wait,
  output logic          link_frame,
  output link_byte_t    link_byte
);

  emesh_word_t rr_word;
  emesh_word_t rq_word;
  emesh_word_t wr_word;
  emesh_word_t rr_head;
  emesh_word_t rq_head;
  emesh_word_t wr_head;
  logic        rr_empty;
  logic        rq_empty;
  logic        wr_empty;
  logic        rr_rd_en;
  logic        rq_rd_en;
  logic        wr_rd_en;

  emesh_if tx_if ();

  // packets enter as fields
  assign rr_word.pkt = rr_packet;
  assign rq_word.pkt = rq_packet;
  assign wr_word.pkt = wr_packet;

  // ##################################################
  // channel fifos
  // ##################################################
  etx_fifo fifo_rr (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .push(rr_push), .push_data(rr_word),
    .rd_en(rr_rd_en), .rd_data(rr_head),
    .empty(rr_empty), .full(rr_full)
  );

  etx_fifo fifo_rq (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .push(rq_push), .push_data(rq_word),
    .rd_en(rq_rd_en), .rd_data(rq_head),
    .empty(rq_empty), .full(rq_full)
  );

  etx_fifo fifo_wr (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .push(wr_push), .push_data(wr_word),
    .rd_en(wr_rd_en), .rd_data(wr_head),
    .empty(wr_empty), .full(wr_full)
  );

  // ##################################################
  // arbiter and framer
  // ##################################################
  etx_arbiter arbiter (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .rr_data(rr_head), .rr_empty(rr_empty), .rr_rd_en(rr_rd_en),
    .rq_data(rq_head), .rq_empty(rq_empty), .rq_rd_en(rq_rd_en),
    .wr_data(wr_head), .wr_empty(wr_empty), .wr_rd_en(wr_rd_en),
    .rd_wait(link_rd_wait), .wr_wait(link_wr_wait),
    .tx(tx_if.master)
  );

  etx_framer framer (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .rx(tx_if.slave),
    .link_frame(link_frame), .link_byte(link_byte)
  );

endmodule

// File: sim/etx_assertions.sv
`timescale 1ns/1ps

module etx_assertions (
  input logic       tx_lclk_par,
  input logic       reset,
  // {rr, rq, wr}
  input logic [2:0] rd_en,
  input logic [2:0] empty,
  input logic       access,
  input logic       ack,
  input logic       link_frame
);

  // ##################################################
  // arbiter pops
  // ##################################################

  // one fifo per pick
  a_one_pop: assert property (@(posedge tx_lclk_par) disable iff (reset)
    $onehot0(rd_en))
    else $error("more than one fifo popped in one cycle");

  // never pop an empty fifo
  a_pop_not_empty: assert property (@(posedge tx_lclk_par) disable iff (reset)
    (rd_en & empty) == 3'b000)
    else $error("fifo popped while empty");

  // ##################################################
  // emesh handshake and link frame
  // ##################################################
  a_ack_access: assert property (@(posedge tx_lclk_par) disable iff (reset)
    ack |-> access)
    else $error("ack without access");

  // frame may only drop right after its last byte
  a_frame_cont: assert property (@(posedge tx_lclk_par) disable iff (reset)
    (link_frame && !ack) |=> link_frame)
    else $error("link_frame dropped inside a frame");

endmodule

// File: sim/etx_tb.sv
`timescale 1ns/1ps
`include "etx_settings.svh"

module etx_tb import emesh_pkg::*, etx_link_pkg::*; ();

  localparam int N_PATTERNS = 32;

  logic          tx_lclk_par;
  logic          reset;
  emesh_packet_t rr_packet;
  logic          rr_push;
  logic          rr_full;
  emesh_packet_t rq_packet;
  logic          rq_push;
  logic          rq_full;
  emesh_packet_t wr_packet;
  logic          wr_push;
  logic          wr_full;
  logic          link_rd_wait;
  logic          link_wr_wait;
  logic          link_frame;
  link_byte_t    link_byte;

  // tag byte {phase, channel} above the 104 bit packet
  logic [111:0]  patterns [N_PATTERNS];
  // expected frames in link order, with their source channel
  emesh_word_t   exp_q [$];
  etx_chan_t     exp_chan_q [$];

  int mismatches = 0;
  int failures   = 0;
  int frames     = 0;

  etx_top etx_top_inst (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .rr_packet(rr_packet), .rr_push(rr_push), .rr_full(rr_full),
    .rq_packet(rq_packet), .rq_push(rq_push), .rq_full(rq_full),
    .wr_packet(wr_packet), .wr_push(wr_push), .wr_full(wr_full),
    .link_rd_wait(link_rd_wait), .link_wr_wait(link_wr_wait),
    .link_frame(link_frame), .link_byte(link_byte)
  );

  bind etx_top etx_assertions assertions_inst (
    .tx_lclk_par(tx_lclk_par), .reset(reset),
    .rd_en({rr_rd_en, rq_rd_en, wr_rd_en}),
    .empty({rr_empty, rq_empty, wr_empty}),
    .access(tx_if.access), .ack(tx_if.ack),
    .link_frame(link_frame)
  );

  // 8 ns period
  always #4 tx_lclk_par = ~tx_lclk_par;

  // ##################################################
  // compare tasks
  // ##################################################
  task automatic check_byte(input link_byte_t got, input link_byte_t want,
                            input frame_cnt_t idx);
    if (got !== want) begin
      mismatches++;
      $display("Mismatch at %0d ns: frame %0d byte %0d is %02h, expected %02h",
               $time, frames, idx, got, want);
    end
  endtask

  task automatic check_frame_len(input frame_cnt_t got, input frame_cnt_t want);
    if (got !== want) begin
      mismatches++;
      $display("Mismatch at %0d ns: frame %0d has %0d bytes, expected %0d",
               $time, frames, got, want);
    end
  endtask

  task automatic check_full(input logic got, input logic want, input etx_chan_t ch);
    if (got !== want) begin
      mismatches++;
      $display("Mismatch at %0d ns: %s fifo full is %b, expected %b",
               $time, ch.name(), got, want);
    end
  endtask

  // ##################################################
  // stimulus, driven on the rising edge
  // ##################################################
  task automatic push_packet(input etx_chan_t ch, input emesh_packet_t pkt);
    @(posedge tx_lclk_par);
    rr_push   <= (ch == CHAN_RR);
    rq_push   <= (ch == CHAN_RQ);
    wr_push   <= (ch == CHAN_WR);
    // only the pushed channel takes it
    rr_packet <= pkt;
    rq_packet <= pkt;
    wr_packet <= pkt;
  endtask

  task automatic stop_pushes();
    @(posedge tx_lclk_par);
    rr_push <= 1'b0;
    rq_push <= 1'b0;
    wr_push <= 1'b0;
  endtask

  task automatic set_waits(input logic rd, input logic wr);
    @(posedge tx_lclk_par);
    link_rd_wait <= rd;
    link_wr_wait <= wr;
  endtask

  // all entries of one phase, file order
  task automatic push_phase(input logic [3:0] phase);
    for (int i = 0; i < N_PATTERNS; i++) begin
      if (patterns[i][111:108] == phase) begin
        push_packet(etx_chan_t'(patterns[i][105:104]), patterns[i][103:0]);
      end
    end
    stop_pushes();
  endtask

  // ##################################################
  // expected stream model
  // ##################################################

  // fifo order inside a channel
  task automatic queue_channel(input logic [3:0] phase, input etx_chan_t ch);
    for (int i = 0; i < N_PATTERNS; i++) begin
      if (patterns[i][111:108] == phase && etx_chan_t'(patterns[i][105:104]) == ch) begin
        exp_q.push_back(patterns[i][103:0]);
        exp_chan_q.push_back(ch);
      end
    end
  endtask

  // responses, then requests, then writes
  task automatic queue_priority(input logic [3:0] phase);
    queue_channel(phase, CHAN_RR);
    queue_channel(phase, CHAN_RQ);
    queue_channel(phase, CHAN_WR);
  endtask

  // entries of one channel pushed in a phase
  function automatic int count_entries(input logic [3:0] phase, input etx_chan_t ch);
    int n;
    n = 0;
    for (int i = 0; i < N_PATTERNS; i++) begin
      if (patterns[i][111:108] == phase && etx_chan_t'(patterns[i][105:104]) == ch) begin
        n++;
      end
    end
    return n;
  endfunction

  // held fifos fill up only on a burst of the full depth
  task automatic expect_full_flags(input logic [3:0] phase);
    @(negedge tx_lclk_par);
    check_full(rr_full, count_entries(phase, CHAN_RR) >= `ETX_FIFO_DEPTH, CHAN_RR);
    check_full(rq_full, count_entries(phase, CHAN_RQ) >= `ETX_FIFO_DEPTH, CHAN_RQ);
    check_full(wr_full, count_entries(phase, CHAN_WR) >= `ETX_FIFO_DEPTH, CHAN_WR);
  endtask

  // ##################################################
  // link monitor, sampled on the falling edge
  // ##################################################
  task automatic expect_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge tx_lclk_par);
      if (link_frame) begin
        failures++;
        $display("Error at %0d ns: link frame active while the link should be idle", $time);
      end
    end
  endtask

  task automatic expect_frame(input emesh_word_t want, input etx_chan_t ch,
                              input logic tight);
    int         waited;
    frame_cnt_t want_len;
    frame_cnt_t got_len;
    frame_cnt_t lane;
    waited  = 0;
    got_len = '0;
    // read requests stop after the source address
    want_len = (ch == CHAN_RQ) ? frame_cnt_t'(`ETX_RQ_BYTES) : frame_cnt_t'(`ETX_FULL_BYTES);
    while (!link_frame && waited < `ETX_TIMEOUT) begin
      @(negedge tx_lclk_par);
      waited++;
    end
    if (!link_frame) begin
      failures++;
      $display("Timeout at %0d ns: no link frame within %0d cycles", $time, `ETX_TIMEOUT);
    end else begin
      frames++;
      // back to back frames leave no gap
      if (tight && waited != 0) begin
        failures++;
        $display("Error at %0d ns: %0d idle cycles before frame %0d", $time, waited, frames);
      end
      while (link_frame && got_len < want_len) begin
        // msb lane first
        lane = frame_cnt_t'(`ETX_FULL_BYTES - 1) - got_len;
        check_byte(link_byte, want.lanes[lane], got_len);
        got_len++;
        @(negedge tx_lclk_par);
      end
      check_frame_len(got_len, want_len);
    end
  endtask

  task automatic drain_expected(input logic tight_first);
    emesh_word_t want;
    etx_chan_t   ch;
    logic        tight;
    tight = tight_first;
    @(negedge tx_lclk_par);
    while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      ch   = exp_chan_q.pop_front();
      expect_frame(want, ch, tight);
      tight = 1'b1;
    end
  endtask

  // ##################################################
  // test sequence
  // ##################################################
  initial begin
    tx_lclk_par = 1'b0;
    reset        <= 1'b1;
    rr_packet    <= '0;
    rr_push      <= 1'b0;
    rq_packet    <= '0;
    rq_push      <= 1'b0;
    wr_packet    <= '0;
    wr_push      <= 1'b0;
    link_rd_wait <= 1'b0;
    link_wr_wait <= 1'b0;
    // unused slots hold phase f
    for (int i = 0; i < N_PATTERNS; i++) begin
      patterns[i] = '1;
    end
    $readmemh("sim/etx_patterns.txt", patterns);
    repeat (4) @(posedge tx_lclk_par);
    reset <= 1'b0;

    // quiet link, then one write with no waits
    expect_idle(20);
    push_phase(4'd1);
    queue_priority(4'd1);
    drain_expected(1'b0);
    expect_idle(4);

    // full preload held by both waits
    set_waits(1'b1, 1'b1);
    push_phase(4'd2);
    expect_full_flags(4'd2);
    queue_priority(4'd2);
    set_waits(1'b0, 1'b0);
    drain_expected(1'b0);
    expect_idle(4);

    // writes and responses held, requests flow
    set_waits(1'b1, 1'b1);
    push_phase(4'd3);
    expect_full_flags(4'd3);
    queue_channel(4'd3, CHAN_RQ);
    set_waits(1'b0, 1'b1);
    drain_expected(1'b0);
    expect_idle(20);
    queue_channel(4'd3, CHAN_RR);
    queue_channel(4'd3, CHAN_WR);
    set_waits(1'b0, 1'b0);
    drain_expected(1'b0);
    expect_idle(4);

    $display("frames checked %0d, mismatches %0d, other errors %0d",
             frames, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/etx_patterns.txt
// tag byte: phase nibble, channel nibble (0 rr, 1 rq, 2 wr)
// then the packet msb first: header byte, dstaddr, srcaddr, data
// phase 1: single write to an idle link
125a8000010000000000deadbeef
// phase 2: preload with both waits high, then release both
2253800002000000000011111111
21208000021000000420cafef00d
206c0000043080000300a5a5a5a5
2259800002040000000022222222
206c00000434800003045a5a5a5a
2124800002140000042400000000
// phase 3: read requests only while writes wait
307f000004408000040001234567
313a8000050000000440ffffffff
324f800006000000000089abcdef
3108800005040000044400000000
3070000004448000040476543210
32418000060400000000fedcba98

// File: vlog.f
+incdir+include
rtl/etx_link_pkg.sv
rtl/emesh_pkg.sv
rtl/emesh_if.sv
rtl/etx_fifo.sv
rtl/etx_arbiter.sv
rtl/etx_framer.sv
rtl/etx_top.sv
sim/etx_assertions.sv
sim/etx_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = etx_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# an abnormal exit counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
